/* src/frame_reader_defines.svh */
/*
 * Frame reader build constants
 * Bus widths, burst shape, image index widths and FIFO sizing
 */
`ifndef FRAME_READER_DEFINES_SVH
`define FRAME_READER_DEFINES_SVH

// ----------------------------------------
// AXI read bus
// ----------------------------------------
`define FR_ADDR_W        32
`define FR_DATA_W        32
`define FR_BURST_LEN     4

// ----------------------------------------
// Image geometry and buffering
// ----------------------------------------
`define FR_WBITS         12
`define FR_HBITS         12
`define FR_FIFO_DEPTH    16
`define FR_PIX_PER_WORD  4

`endif

/* src/axi_rd_pkg.sv */
/*
 * AXI read side types
 * Address and data words, fetch FSM states and RRESP codes
 */
`default_nettype none
`include "frame_reader_defines.svh"

package axi_rd_pkg;

	typedef logic [`FR_ADDR_W-1:0] axi_addr_t;
	typedef logic [`FR_DATA_W-1:0] axi_data_t;

	// Burst sequencing in mm2fifo
	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_ADDR,
		FETCH_DATA
	} fetch_state_t;

	// Encoding as on the RRESP wires
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} rresp_t;

endpackage

`default_nettype wire

/* src/video_pkg.sv */
/*
 * Video stream types
 * Pixel word and the unpacker FSM states
 */
`default_nettype none

package video_pkg;

	// 8-bit monochrome pixel
	typedef logic [7:0] pixel_t;

	typedef enum logic {
		UNPACK_EMPTY,
		UNPACK_SHIFT
	} unpack_state_t;

endpackage

`default_nettype wire

/* src/mm2fifo.sv */
/*
 * mm2fifo
 * AXI4 read burst master that walks an image frame by frame and
 * writes the returned words, tagged with sof and eol, into a FIFO
 */
`default_nettype none
`include "frame_reader_defines.svh"

module mm2fifo (
	input  logic                  M_AXI_ACLK,
	input  logic                  M_AXI_ARESETN,
	input  logic                  enable,
	input  axi_rd_pkg::axi_addr_t base_addr,
	input  logic [`FR_WBITS-1:0]  img_width,
	input  logic [`FR_HBITS-1:0]  img_height,
	output axi_rd_pkg::axi_addr_t M_AXI_ARADDR,
	output logic [7:0]            M_AXI_ARLEN,
	output logic [2:0]            M_AXI_ARSIZE,
	output logic [1:0]            M_AXI_ARBURST,
	output logic                  M_AXI_ARVALID,
	input  logic                  M_AXI_ARREADY,
	input  axi_rd_pkg::axi_data_t M_AXI_RDATA,
	input  logic [1:0]            M_AXI_RRESP,
	input  logic                  M_AXI_RLAST,
	input  logic                  M_AXI_RVALID,
	output logic                  M_AXI_RREADY,
	output logic                  wr_en,
	output axi_rd_pkg::axi_data_t wr_data,
	output logic                  wr_sof,
	output logic                  wr_eol,
	input  logic                  full,
	output logic                  frame_pulse,
	output logic                  read_error
);

	localparam axi_rd_pkg::axi_addr_t burst_bytes =
		`FR_ADDR_W'(`FR_BURST_LEN * `FR_DATA_W / 8);
	localparam logic [`FR_WBITS-1:0] col_step = `FR_WBITS'(`FR_PIX_PER_WORD);

	axi_rd_pkg::fetch_state_t state;
	axi_rd_pkg::rresp_t       resp;
	axi_rd_pkg::axi_addr_t    araddr;
	logic                     arvalid;
	logic                     frame_start;
	logic                     sof_pending;
	logic [`FR_WBITS-1:0]     col_left;
	logic [`FR_HBITS-1:0]     row_left;
	logic                     rnext;
	logic                     start_burst;
	logic                     frame_done;

	// Fixed burst shape, 4-byte beats
	assign M_AXI_ARADDR  = araddr;
	assign M_AXI_ARLEN   = 8'(`FR_BURST_LEN - 1);
	assign M_AXI_ARSIZE  = 3'($clog2(`FR_DATA_W / 8));
	assign M_AXI_ARBURST = 2'b01;
	assign M_AXI_ARVALID = arvalid;
	assign M_AXI_RREADY  = ~full;

	assign rnext       = M_AXI_RVALID && M_AXI_RREADY;
	assign start_burst = (state == axi_rd_pkg::FETCH_IDLE) && enable && !full;
	assign frame_done  = rnext && (col_left == '0) && (row_left == '0);
	assign resp        = axi_rd_pkg::rresp_t'(M_AXI_RRESP);

	// FIFO side, one word per accepted beat
	assign wr_en   = rnext;
	assign wr_data = M_AXI_RDATA;
	assign wr_sof  = sof_pending;
	assign wr_eol  = (col_left == '0);

	// ----------------------------------------
	// Burst sequencing
	// ----------------------------------------
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			state   <= axi_rd_pkg::FETCH_IDLE;
			arvalid <= 1'b0;
		end else begin
			case (state)
				axi_rd_pkg::FETCH_IDLE: begin
					if (start_burst) begin
						state   <= axi_rd_pkg::FETCH_ADDR;
						arvalid <= 1'b1;
					end
				end
				axi_rd_pkg::FETCH_ADDR: begin
					// Hold the request until the slave takes it
					if (M_AXI_ARREADY) begin
						state   <= axi_rd_pkg::FETCH_DATA;
						arvalid <= 1'b0;
					end
				end
				axi_rd_pkg::FETCH_DATA: begin
					if (rnext && M_AXI_RLAST)
						state <= axi_rd_pkg::FETCH_IDLE;
				end
				default: state <= axi_rd_pkg::FETCH_IDLE;
			endcase
		end
	end

	// First burst of a frame reads from base, later ones step on
	always_ff @(posedge M_AXI_ACLK) begin
		if (start_burst)
			araddr <= frame_start ? base_addr : araddr + burst_bytes;
	end

	// ----------------------------------------
	// Frame and line tracking
	// ----------------------------------------
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			frame_start <= 1'b1;
			sof_pending <= 1'b0;
			frame_pulse <= 1'b0;
		end else begin
			frame_pulse <= start_burst && frame_start;
			if (start_burst) begin
				frame_start <= 1'b0;
				sof_pending <= frame_start;
			end else begin
				if (frame_done)
					frame_start <= 1'b1;
				if (rnext)
					sof_pending <= 1'b0;
			end
		end
	end

	// Down-counters, col in pixels and row in lines
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			col_left <= '0;
			row_left <= '0;
		end else if (start_burst && frame_start) begin
			col_left <= img_width - col_step;
			row_left <= img_height - 1'b1;
		end else if (rnext) begin
			if (col_left != '0) begin
				col_left <= col_left - col_step;
			end else if (row_left != '0) begin
				col_left <= img_width - col_step;
				row_left <= row_left - 1'b1;
			end
		end
	end

	// SLVERR and DECERR both carry bit 1
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN)
			read_error <= 1'b0;
		else
			read_error <= rnext && (resp == axi_rd_pkg::RESP_SLVERR ||
				resp == axi_rd_pkg::RESP_DECERR);
	end

endmodule

`default_nettype wire

/* src/line_fifo.sv */
/*
 * line_fifo
 * First-word-fall-through FIFO for AXI words with sof and eol tags
 */
`default_nettype none
`include "frame_reader_defines.svh"

module line_fifo (
	input  logic                  M_AXI_ACLK,
	input  logic                  M_AXI_ARESETN,
	input  logic                  wr_en,
	input  axi_rd_pkg::axi_data_t wr_data,
	input  logic                  wr_sof,
	input  logic                  wr_eol,
	output logic                  full,
	input  logic                  rd_en,
	output axi_rd_pkg::axi_data_t rd_data,
	output logic                  rd_sof,
	output logic                  rd_eol,
	output logic                  empty
);

	localparam int ptr_w = $clog2(`FR_FIFO_DEPTH);
	localparam logic [ptr_w:0] depth = (ptr_w + 1)'(`FR_FIFO_DEPTH);

	// Entry is {sof, eol, data}
	logic [`FR_DATA_W+1:0] mem [`FR_FIFO_DEPTH];
	logic [ptr_w-1:0]      wr_ptr;
	logic [ptr_w-1:0]      rd_ptr;
	logic [ptr_w:0]        count;
	logic [ptr_w:0]        count_next;
	logic                  do_wr;
	logic                  do_rd;

	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	assign {rd_sof, rd_eol, rd_data} = mem[rd_ptr];

	always_comb begin
		count_next = count;
		if (do_wr && !do_rd)
			count_next = count + 1'b1;
		else if (do_rd && !do_wr)
			count_next = count - 1'b1;
	end

	always_ff @(posedge M_AXI_ACLK) begin
		if (do_wr)
			mem[wr_ptr] <= {wr_sof, wr_eol, wr_data};
	end

	// Pointers wrap on their own, depth is a power of two
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			full   <= 1'b0;
			empty  <= 1'b1;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count_next;
			full  <= (count_next == depth);
			empty <= (count_next == '0);
		end
	end

endmodule

`default_nettype wire

/* src/pixel_unpack.sv */
/*
 * pixel_unpack
 * Pops one FIFO word and emits its pixels lowest byte first,
 * one per clock, carrying the sof and eol tags
 */
`default_nettype none
`include "frame_reader_defines.svh"

module pixel_unpack (
	input  logic                  M_AXI_ACLK,
	input  logic                  M_AXI_ARESETN,
	input  axi_rd_pkg::axi_data_t rd_data,
	input  logic                  rd_sof,
	input  logic                  rd_eol,
	input  logic                  empty,
	output logic                  rd_en,
	output logic                  pix_valid,
	output video_pkg::pixel_t     pix_data,
	output logic                  pix_sof,
	output logic                  pix_eol
);

	localparam int pix_w = $bits(video_pkg::pixel_t);
	localparam int idx_w = $clog2(`FR_PIX_PER_WORD);
	localparam logic [idx_w-1:0] last_idx = idx_w'(`FR_PIX_PER_WORD - 1);

	video_pkg::unpack_state_t state;
	axi_rd_pkg::axi_data_t    shift_q;
	logic [idx_w-1:0]         idx;
	logic                     sof_tag;
	logic                     eol_tag;

	// Load and pop happen in the same cycle
	assign rd_en = (state == video_pkg::UNPACK_EMPTY) && !empty;

	assign pix_valid = (state == video_pkg::UNPACK_SHIFT);
	assign pix_data  = shift_q[pix_w-1:0];
	assign pix_sof   = pix_valid && (idx == '0) && sof_tag;
	assign pix_eol   = pix_valid && (idx == last_idx) && eol_tag;

	// ----------------------------------------
	// Control
	// ----------------------------------------
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			state <= video_pkg::UNPACK_EMPTY;
			idx   <= '0;
		end else begin
			case (state)
				video_pkg::UNPACK_EMPTY: begin
					if (rd_en) begin
						state <= video_pkg::UNPACK_SHIFT;
						idx   <= '0;
					end
				end
				video_pkg::UNPACK_SHIFT: begin
					idx <= idx + 1'b1;
					if (idx == last_idx)
						state <= video_pkg::UNPACK_EMPTY;
				end
				default: state <= video_pkg::UNPACK_EMPTY;
			endcase
		end
	end

	// Word and tags
	always_ff @(posedge M_AXI_ACLK) begin
		if (rd_en) begin
			shift_q <= rd_data;
			sof_tag <= rd_sof;
			eol_tag <= rd_eol;
		end else if (pix_valid) begin
			shift_q <= shift_q >> pix_w;
		end
	end

endmodule

`default_nettype wire

/* src/frame_reader_top.sv */
/*
 * frame_reader_top
 * Video frame reader: AXI burst fetch, line FIFO and pixel unpacker
 */
`default_nettype none
`include "frame_reader_defines.svh"

module frame_reader_top (
	input  logic                  M_AXI_ACLK,
	input  logic                  M_AXI_ARESETN,
	input  logic                  enable,
	input  axi_rd_pkg::axi_addr_t base_addr,
	input  logic [`FR_WBITS-1:0]  img_width,
	input  logic [`FR_HBITS-1:0]  img_height,
	output axi_rd_pkg::axi_addr_t M_AXI_ARADDR,
	output logic [7:0]            M_AXI_ARLEN,
	output logic [2:0]            M_AXI_ARSIZE,
	output logic [1:0]            M_AXI_ARBURST,
	output logic                  M_AXI_ARVALID,
	input  logic                  M_AXI_ARREADY,
	input  axi_rd_pkg::axi_data_t M_AXI_RDATA,
	input  logic [1:0]            M_AXI_RRESP,
	input  logic                  M_AXI_RLAST,
	input  logic                  M_AXI_RVALID,
	output logic                  M_AXI_RREADY,
	output logic                  pix_valid,
	output video_pkg::pixel_t     pix_data,
	output logic                  pix_sof,
	output logic                  pix_eol,
	output logic                  frame_pulse,
	output logic                  read_error
);

	// Fetch to buffer
	logic                  wr_en;
	axi_rd_pkg::axi_data_t wr_data;
	logic                  wr_sof;
	logic                  wr_eol;
	logic                  full;

	// Buffer to unpack
	logic                  rd_en;
	axi_rd_pkg::axi_data_t rd_data;
	logic                  rd_sof;
	logic                  rd_eol;
	logic                  empty;

	mm2fifo mm2fifo_i (
		.M_AXI_ACLK    (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.enable        (enable),
		.base_addr     (base_addr),
		.img_width     (img_width),
		.img_height    (img_height),
		.M_AXI_ARADDR  (M_AXI_ARADDR),
		.M_AXI_ARLEN   (M_AXI_ARLEN),
		.M_AXI_ARSIZE  (M_AXI_ARSIZE),
		.M_AXI_ARBURST (M_AXI_ARBURST),
		.M_AXI_ARVALID (M_AXI_ARVALID),
		.M_AXI_ARREADY (M_AXI_ARREADY),
		.M_AXI_RDATA   (M_AXI_RDATA),
		.M_AXI_RRESP   (M_AXI_RRESP),
		.M_AXI_RLAST   (M_AXI_RLAST),
		.M_AXI_RVALID  (M_AXI_RVALID),
		.M_AXI_RREADY  (M_AXI_RREADY),
		.wr_en         (wr_en),
		.wr_data       (wr_data),
		.wr_sof        (wr_sof),
		.wr_eol        (wr_eol),
		.full          (full),
		.frame_pulse   (frame_pulse),
		.read_error    (read_error)
	);

	line_fifo line_fifo_i (
		.M_AXI_ACLK    (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.wr_en         (wr_en),
		.wr_data       (wr_data),
		.wr_sof        (wr_sof),
		.wr_eol        (wr_eol),
		.full          (full),
		.rd_en         (rd_en),
		.rd_data       (rd_data),
		.rd_sof        (rd_sof),
		.rd_eol        (rd_eol),
		.empty         (empty)
	);

	pixel_unpack pixel_unpack_i (
		.M_AXI_ACLK    (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.rd_data       (rd_data),
		.rd_sof        (rd_sof),
		.rd_eol        (rd_eol),
		.empty         (empty),
		.rd_en         (rd_en),
		.pix_valid     (pix_valid),
		.pix_data      (pix_data),
		.pix_sof       (pix_sof),
		.pix_eol       (pix_eol)
	);

endmodule

`default_nettype wire

/* testbench/axi_mem_model.sv */
/*
 * AXI4 read slave model
 * Computed byte data, random ARREADY and RVALID stalls, and one
 * optional poisoned burst address that answers SLVERR
 */
`default_nettype none
`include "frame_reader_defines.svh"

module axi_mem_model (
	input  wire logic                  aclk,
	input  wire logic                  aresetn,
	input  wire logic                  poison_en,
	input  wire axi_rd_pkg::axi_addr_t poison_addr,
	input  wire axi_rd_pkg::axi_addr_t araddr,
	input  wire logic                  arvalid,
	output logic                       arready,
	output axi_rd_pkg::axi_data_t      rdata,
	output logic [1:0]                 rresp,
	output logic                       rlast,
	output logic                       rvalid,
	input  wire logic                  rready
);

	timeunit 1ns;
	timeprecision 100ps;

	integer                seed;
	logic                  busy;
	logic                  poisoned;
	logic                  r_hold;
	axi_rd_pkg::axi_addr_t addr;
	logic [7:0]            beat;

	// Byte at address a is a[7:0] ^ 5A, lowest address in the lowest byte
	function automatic axi_rd_pkg::axi_data_t word_at(input axi_rd_pkg::axi_addr_t a);
		axi_rd_pkg::axi_data_t w;
		for (int i = 0; i < `FR_DATA_W / 8; i++)
			w[8*i +: 8] = 8'(a + i) ^ 8'h5A;
		return w;
	endfunction

	initial begin
		seed    = 32'h1b45;
		arready = 1'b0;
		rvalid  = 1'b0;
		rlast   = 1'b0;
		rresp   = 2'b00;
		rdata   = '0;
	end

	// Handshake bookkeeping
	always @(posedge aclk) begin
		if (!aresetn) begin
			busy     <= 1'b0;
			beat     <= '0;
			r_hold   <= 1'b0;
			poisoned <= 1'b0;
		end else begin
			if (arvalid && arready && !busy) begin
				busy     <= 1'b1;
				addr     <= araddr;
				beat     <= '0;
				poisoned <= poison_en && (araddr == poison_addr);
			end
			r_hold <= rvalid && !rready;
			if (rvalid && rready) begin
				beat <= beat + 1'b1;
				if (rlast)
					busy <= 1'b0;
			end
		end
	end

	// Outputs change on the falling edge
	always @(negedge aclk) begin
		arready = !busy && (($random(seed) & 3) != 0);
		if (!busy) begin
			rvalid = 1'b0;
			rlast  = 1'b0;
		end else if (!r_hold) begin
			// A beat offered and not yet taken stays as it is
			rvalid = ($random(seed) & 3) != 0;
			rdata  = word_at(addr + 4 * beat);
			rlast  = (beat == `FR_BURST_LEN - 1);
			rresp  = poisoned ? 2'(axi_rd_pkg::RESP_SLVERR) : 2'(axi_rd_pkg::RESP_OKAY);
		end
	end

endmodule

`default_nettype wire

/* testbench/frame_reader_props.sv */
/*
 * AXI read protocol properties, bound into mm2fifo
 */
`default_nettype none
`include "frame_reader_defines.svh"

module frame_reader_props (
	input wire logic                  M_AXI_ACLK,
	input wire logic                  M_AXI_ARESETN,
	input wire axi_rd_pkg::axi_addr_t base_addr,
	input wire logic [`FR_WBITS-1:0]  img_width,
	input wire logic [`FR_HBITS-1:0]  img_height,
	input wire axi_rd_pkg::axi_addr_t M_AXI_ARADDR,
	input wire logic                  M_AXI_ARVALID,
	input wire logic                  M_AXI_ARREADY,
	input wire logic                  M_AXI_RVALID,
	input wire logic                  M_AXI_RREADY,
	input wire logic                  M_AXI_RLAST,
	input wire logic                  full
);

	timeunit 1ns;
	timeprecision 100ps;

	int                    fail_count = 0;
	logic                  burst_open;
	axi_rd_pkg::axi_addr_t frame_last;

	// Last byte address of the frame, one byte per pixel
	assign frame_last = base_addr + `FR_ADDR_W'(img_width) * `FR_ADDR_W'(img_height) - 1;

	// Open from the AR handshake to the RLAST beat
	always @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN)
			burst_open <= 1'b0;
		else if (M_AXI_ARVALID && M_AXI_ARREADY)
			burst_open <= 1'b1;
		else if (M_AXI_RVALID && M_AXI_RREADY && M_AXI_RLAST)
			burst_open <= 1'b0;
	end

	ar_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		M_AXI_ARVALID && !M_AXI_ARREADY |=> M_AXI_ARVALID && $stable(M_AXI_ARADDR))
	else begin
		$error("ARVALID dropped or ARADDR changed before ARREADY");
		fail_count++;
	end

	ar_range: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		M_AXI_ARVALID |-> M_AXI_ARADDR[3:0] == 4'h0 &&
			M_AXI_ARADDR >= base_addr && M_AXI_ARADDR <= frame_last)
	else begin
		$error("ARADDR not aligned or outside the frame");
		fail_count++;
	end

	rready_full: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		M_AXI_RREADY == !full)
	else begin
		$error("RREADY is not the inverse of FIFO full");
		fail_count++;
	end

	single_burst: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
		!(M_AXI_ARVALID && burst_open))
	else begin
		$error("Second ARVALID before RLAST of the open burst");
		fail_count++;
	end

endmodule

bind mm2fifo frame_reader_props props_i (
	.M_AXI_ACLK    (M_AXI_ACLK),
	.M_AXI_ARESETN (M_AXI_ARESETN),
	.base_addr     (base_addr),
	.img_width     (img_width),
	.img_height    (img_height),
	.M_AXI_ARADDR  (M_AXI_ARADDR),
	.M_AXI_ARVALID (M_AXI_ARVALID),
	.M_AXI_ARREADY (M_AXI_ARREADY),
	.M_AXI_RVALID  (M_AXI_RVALID),
	.M_AXI_RREADY  (M_AXI_RREADY),
	.M_AXI_RLAST   (M_AXI_RLAST),
	.full          (full)
);

`default_nettype wire

/* testbench/tb_frame_reader.sv */
/*
 * Frame reader testbench
 * Runs frames through the reader against the memory model and checks each pixel
 */
`default_nettype none
`include "frame_reader_defines.svh"

module tb_frame_reader;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int period       = 4;
	localparam int frame_pix    = 64;
	localparam int bursts_frame = 4;
	localparam int total_frames = 5;

	logic                  aclk;
	logic                  aresetn;
	logic                  enable;
	axi_rd_pkg::axi_addr_t base_addr;
	logic [`FR_WBITS-1:0]  img_width;
	logic [`FR_HBITS-1:0]  img_height;
	logic                  poison_en;
	axi_rd_pkg::axi_addr_t araddr;
	logic [7:0]            arlen;
	logic [2:0]            arsize;
	logic [1:0]            arburst;
	logic                  arvalid;
	logic                  arready;
	axi_rd_pkg::axi_data_t rdata;
	logic [1:0]            rresp;
	logic                  rlast;
	logic                  rvalid;
	logic                  rready;
	logic                  pix_valid;
	video_pkg::pixel_t     pix_data;
	logic                  pix_sof;
	logic                  pix_eol;
	logic                  frame_pulse;
	logic                  read_error;

	// Checker state
	axi_rd_pkg::axi_addr_t cur_base;
	logic                  quiet;
	int                    errors = 0;
	int                    pix_count = 0;
	int                    ar_count = 0;
	int                    frame_pulses = 0;
	int                    pulses_ahead = 0;
	int                    err_pulses = 0;
	int                    tests_passed = 0;
	int                    tests_failed = 0;
	int                    k;
	logic [7:0]            exp_pix;

	frame_reader_top frame_reader_top_i (
		.M_AXI_ACLK    (aclk),
		.M_AXI_ARESETN (aresetn),
		.enable        (enable),
		.base_addr     (base_addr),
		.img_width     (img_width),
		.img_height    (img_height),
		.M_AXI_ARADDR  (araddr),
		.M_AXI_ARLEN   (arlen),
		.M_AXI_ARSIZE  (arsize),
		.M_AXI_ARBURST (arburst),
		.M_AXI_ARVALID (arvalid),
		.M_AXI_ARREADY (arready),
		.M_AXI_RDATA   (rdata),
		.M_AXI_RRESP   (rresp),
		.M_AXI_RLAST   (rlast),
		.M_AXI_RVALID  (rvalid),
		.M_AXI_RREADY  (rready),
		.pix_valid     (pix_valid),
		.pix_data      (pix_data),
		.pix_sof       (pix_sof),
		.pix_eol       (pix_eol),
		.frame_pulse   (frame_pulse),
		.read_error    (read_error)
	);

	axi_mem_model mem_i (
		.aclk        (aclk),
		.aresetn     (aresetn),
		.poison_en   (poison_en),
		.poison_addr (32'h1010),
		.araddr      (araddr),
		.arvalid     (arvalid),
		.arready     (arready),
		.rdata       (rdata),
		.rresp       (rresp),
		.rlast       (rlast),
		.rvalid      (rvalid),
		.rready      (rready)
	);

	always #(period / 2) aclk = ~aclk;

	// ----------------------------------------
	// Pixel checker
	// ----------------------------------------
	always @(posedge aclk) begin
		if (aresetn) begin
			if (frame_pulse) begin
				pulses_ahead++;
				frame_pulses++;
			end
			if (read_error)
				err_pulses++;
			if (arvalid && arready)
				ar_count++;
			// Fixed burst shape: 4 beats of 4 bytes, INCR
			if (arvalid) begin
				assert (arlen == 8'h03) else begin
					$display("Mismatch arlen: got 0x%h, expected 0x03", arlen);
					errors++;
				end
				assert (arsize == 3'h2) else begin
					$display("Mismatch arsize: got 0x%h, expected 0x2", arsize);
					errors++;
				end
				assert (arburst == 2'h1) else begin
					$display("Mismatch arburst: got 0x%h, expected 0x1", arburst);
					errors++;
				end
			end
			if (quiet) begin
				assert (!arvalid && !pix_valid) else begin
					$display("Activity on ARVALID or pix_valid while enable is low");
					errors++;
				end
			end
			if (pix_valid) begin
				k = pix_count % frame_pix;
				exp_pix = 8'(cur_base + k) ^ 8'h5A;
				assert (pix_data == exp_pix) else begin
					$display("Mismatch pix_data at pixel %0d: got 0x%h, expected 0x%h",
						k, pix_data, exp_pix);
					errors++;
				end
				assert (pix_sof == (k == 0)) else begin
					$display("Mismatch pix_sof at pixel %0d: got 0x%h, expected 0x%h",
						k, pix_sof, (k == 0));
					errors++;
				end
				assert (pix_eol == (k % 16 == 15)) else begin
					$display("Mismatch pix_eol at pixel %0d: got 0x%h, expected 0x%h",
						k, pix_eol, (k % 16 == 15));
					errors++;
				end
				if (pix_sof) begin
					assert (pulses_ahead > 0) else begin
						$display("Start of frame came without a frame_pulse before it");
						errors++;
					end
					pulses_ahead--;
				end
				pix_count++;
			end
		end
	end

	// Drop enable right after the last burst request of the run
	task automatic run_frames(input axi_rd_pkg::axi_addr_t base, input int n);
		int ar_target;
		int pix_target;
		int pulse_start;
		ar_target   = ar_count + n * bursts_frame;
		pix_target  = pix_count + n * frame_pix;
		pulse_start = frame_pulses;
		cur_base    = base;
		base_addr   = base;
		enable      = 1'b1;
		while (ar_count < ar_target)
			@(negedge aclk);
		enable = 1'b0;
		while (pix_count < pix_target)
			@(negedge aclk);
		assert (frame_pulses - pulse_start == n) else begin
			$display("Mismatch frame_pulse count: got 0x%h, expected 0x%h",
				frame_pulses - pulse_start, n);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_start);
		if (errors == err_start) begin
			tests_passed++;
			$display("Test %s: passed", name);
		end else begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, errors - err_start);
		end
	endtask

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------
	initial begin
		int err_start;
		int prop_fails;
		aclk       = 1'b0;
		aresetn    = 1'b0;
		enable     = 1'b0;
		base_addr  = 32'h1000;
		cur_base   = 32'h1000;
		img_width  = 16;
		img_height = 4;
		poison_en  = 1'b0;
		quiet      = 1'b0;
		repeat (8) @(negedge aclk);
		aresetn = 1'b1;
		@(negedge aclk);

		err_start = errors;
		run_frames(32'h1000, 2);
		assert (err_pulses == 0) else begin
			$display("Mismatch read_error count: got 0x%h, expected 0x0", err_pulses);
			errors++;
		end
		report_test("two_frames", err_start);

		err_start = errors;
		run_frames(32'h2000, 1);
		report_test("new_base", err_start);

		// Fetch is parked at a frame boundary here
		err_start = errors;
		quiet = 1'b1;
		repeat (50) @(negedge aclk);
		quiet = 1'b0;
		run_frames(32'h2000, 1);
		report_test("enable_low", err_start);

		// Every beat of the poisoned burst answers SLVERR
		err_start = errors;
		err_pulses = 0;
		poison_en = 1'b1;
		run_frames(32'h1000, 1);
		assert (err_pulses == `FR_BURST_LEN) else begin
			$display("Mismatch read_error count: got 0x%h, expected 0x%h",
				err_pulses, `FR_BURST_LEN);
			errors++;
		end
		report_test("read_error", err_start);

		prop_fails = frame_reader_top_i.mm2fifo_i.props_i.fail_count;
		$display("Tests: %0d passed, %0d failed, %0d check errors, %0d property failures",
			tests_passed, tests_failed, errors, prop_fails);
		if (errors == 0 && tests_failed == 0 && prop_fails == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(total_frames * frame_pix * 20 * period);
		$display("Timeout: the run did not finish in time");
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* frame_reader.f */
+incdir+src
src/axi_rd_pkg.sv
src/video_pkg.sv
src/mm2fifo.sv
src/line_fifo.sv
src/pixel_unpack.sv
src/frame_reader_top.sv
testbench/axi_mem_model.sv
testbench/frame_reader_props.sv
testbench/tb_frame_reader.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the frame reader testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_frame_reader -f frame_reader.f -o sim_frame_reader
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_frame_reader +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q ">>> FAIL" sim.log; then
	exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
	echo "No pass line in sim.log"
	exit 1
fi
exit 0
